// ==== tb/photon_testdata.txt ====
// mode (0 external, 1 generator) rate_sel photons period_len periods, all hex
// Generator lines use period_len 28 for the watchdog only, photons unused
0 0 0c 64 3
0 0 0 32 2
1 1 0 28 3
1 2 0 28 3
1 0 0 28 2
1 3 0 28 2
0 0 10040 200e4 1
0 0 14 60 2
0 0 1e 40 2
1 1 0 28 2

// ==== project.f ====
rtl/photon_pkg.sv
rtl/count_if.sv
rtl/test_signal_gen.sv
rtl/pulse_sync_detect.sv
rtl/photon_gate_counter.sv
rtl/count_result_out.sv
rtl/photon_counter_top.sv
tb/photon_counter_props.sv
tb/tb_photon_counter.sv

// ==== tb/tb_photon_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_photon_counter;
	import photon_pkg::*;

	localparam int NUM_SCEN = 10;
	localparam int FAST_DIV = 2;
	localparam int SLOW_DIV = 5;
	localparam int SYNC_DIV = 20;
	localparam int CLK_NS   = 40;

	logic          clk;
	logic          rst_n;
	logic          test_en;
	test_rate_e    rate_sel;
	logic          photon_in;
	logic          sync_in;
	photon_count_t count;
	period_len_t   period;
	logic          overflow;
	logic          count_valid;
	logic          photon_test;
	logic          sync_test;

	// Five words per scenario: mode, rate, photons, period length, periods
	logic [31:0]   vec [0:NUM_SCEN*5-1];
	integer        seed;
	integer        errors;
	longint        limit_ns;
	integer        sync_edges;
	logic          sync_prev;

	// Generator pins measured per sync_test period
	logic          photon_prev;
	logic          sync_test_prev;
	photon_count_t pin_photons;
	period_len_t   pin_len;
	photon_count_t mon_photons;
	period_len_t   mon_len;

	photon_counter_top #(
		.PHOTON_DIV_FAST (FAST_DIV),
		.PHOTON_DIV_SLOW (SLOW_DIV),
		.SYNC_DIV        (SYNC_DIV)
	) dut (.*);

	always #(CLK_NS/2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run(input string why);
		errors = errors + 1;
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_count(input string name, input photon_count_t got,
			input logic got_ovf, input photon_count_t exp, input logic exp_ovf);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name,
				got, exp));
		if (got_ovf !== exp_ovf)
			stop_run($sformatf("FAIL %0t overflow got %0b expected %0b", $time,
				got_ovf, exp_ovf));
	endtask

	task automatic check_period(input string name, input period_len_t got,
			input period_len_t exp);
		if (got !== exp)
			stop_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name,
				got, exp));
	endtask

	// Nothing published until two sync edges on the selected source
	always @(negedge clk) begin
		if (rst_n && (test_en ? sync_test : sync_in) && !sync_prev && sync_edges < 2)
			sync_edges = sync_edges + 1;
		sync_prev = test_en ? sync_test : sync_in;
		if (sync_edges < 2 && (count_valid || count != 0 || period != 0 || overflow))
			stop_run("Outputs changed before two sync edges had arrived after reset");
	end

	// Photon_test rises counted over each sync_test period
	always @(negedge clk) begin
		if (sync_test && !sync_test_prev) begin
			mon_photons = pin_photons;
			mon_len     = pin_len;
			pin_photons = photon_count_t'(photon_test && !photon_prev);
			pin_len     = period_len_t'(1);
		end else begin
			if (photon_test && !photon_prev)
				pin_photons = pin_photons + 1'b1;
			pin_len = pin_len + 1'b1;
		end
		photon_prev    = photon_test;
		sync_test_prev = sync_test;
	end

	// Watchdog, armed once the budget is known
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		stop_run($sformatf("Timeout: results stopped arriving after %0d ns", limit_ns));
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic to_drive_point;
		@(posedge clk);
		#5;
	endtask

	// Sync high for the first half, photons spread with random gaps
	task automatic drive_external(input int photons, input int len, input int nper);
		int   r;
		int   p;
		int   t;
		logic ph;
		ph = 1'b0;
		// Short low lead-in so the first rise is always seen
		repeat (4) begin
			to_drive_point();
			sync_in   = 1'b0;
			photon_in = 1'b0;
		end
		for (p = 0; p < nper; p++) begin
			r = photons;
			for (t = 0; t < len; t++) begin
				to_drive_point();
				sync_in = (t < len / 2);
				if (ph)
					ph = 1'b0;
				// Forced once only just enough clocks remain
				else if (r > 0 && ((len - t) <= 2 * r - 1 || ($random(seed) & 3) == 0)) begin
					ph = 1'b1;
					r  = r - 1;
				end
				photon_in = ph;
			end
		end
	endtask

	task automatic wait_result;
		do
			@(negedge clk);
		while (count_valid !== 1'b1);
	endtask

	task automatic collect_results(input int nres, input photon_count_t exp_cnt,
			input logic exp_ovf, input period_len_t exp_len, input logic check_pins);
		// Flush detection, then drop the period spanning the switch
		repeat (10) @(negedge clk);
		wait_result();
		repeat (nres) begin
			wait_result();
			check_count("count", count, overflow, exp_cnt, exp_ovf);
			check_period("period", period, exp_len);
			if (check_pins) begin
				// Monitor pins straight from the generator
				check_count("photon_test", mon_photons, 1'b0, exp_cnt, 1'b0);
				check_period("sync_test", mon_len, exp_len);
			end
		end
	endtask

	task automatic run_scenario(input int idx);
		logic [31:0]   mode;
		logic [31:0]   rate;
		logic [31:0]   ph;
		logic [31:0]   len;
		logic [31:0]   nper;
		photon_count_t cnt_max;
		photon_count_t exp_cnt;
		logic          exp_ovf;
		period_len_t   exp_len;
		int            div;
		mode    = vec[idx*5];
		rate    = vec[idx*5+1];
		ph      = vec[idx*5+2];
		len     = vec[idx*5+3];
		nper    = vec[idx*5+4];
		cnt_max = '1;
		if (mode != 0) begin
			// Generator: 2*SYNC_DIV clocks per period, one photon per 2*div
			case (rate)
				1:       div = FAST_DIV;
				2:       div = SLOW_DIV;
				default: div = 0;
			endcase
			exp_len = period_len_t'(2 * SYNC_DIV);
			exp_cnt = (div == 0) ? '0 : photon_count_t'((2 * SYNC_DIV) / (2 * div));
			exp_ovf = 1'b0;
		end else begin
			exp_len = period_len_t'(len);
			exp_cnt = (ph >= cnt_max) ? cnt_max : photon_count_t'(ph);
			exp_ovf = (ph >= cnt_max);
		end
		to_drive_point();
		test_en   = (mode != 0);
		rate_sel  = test_rate_e'(rate[1:0]);
		sync_in   = 1'b0;
		photon_in = 1'b0;
		fork
			if (mode == 0) drive_external(int'(ph), int'(len), int'(nper) + 2);
			collect_results(int'(nper), exp_cnt, exp_ovf, exp_len, (mode != 0));
		join
	endtask

	initial begin
		int     i;
		longint budget;
		clk            = 1'b0;
		rst_n          = 1'b0;
		test_en        = 1'b0;
		rate_sel       = TEST_OFF;
		photon_in      = 1'b0;
		sync_in        = 1'b0;
		seed           = 75;
		errors         = 0;
		limit_ns       = 0;
		sync_edges     = 0;
		sync_prev      = 1'b0;
		photon_prev    = 1'b0;
		sync_test_prev = 1'b0;
		pin_photons    = '0;
		pin_len        = '0;
		mon_photons    = '0;
		mon_len        = '0;
		$readmemh("tb/photon_testdata.txt", vec);
		for (i = 0; i < NUM_SCEN * 5; i++)
			if ($isunknown(vec[i]))
				stop_run($sformatf("Test data file has no value for word %0d", i));
		// Periods plus lead-in and dropped ones, with slack per scenario
		budget = 0;
		for (i = 0; i < NUM_SCEN; i++)
			budget = budget + (longint'(vec[i*5+4]) + 3) * vec[i*5+3] * CLK_NS
				+ 100 * CLK_NS;
		limit_ns = budget;
		repeat (3) @(posedge clk);
		#5;
		rst_n = 1'b1;
		for (i = 0; i < NUM_SCEN; i++)
			run_scenario(i);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/photon_counter_props.sv ====
`timescale 1ns/1ns
`default_nettype none

// Strobe rules shared by the gate counter and the output stage
module photon_counter_props #(
	// Set where the bound module has a waiting state to watch
	parameter bit HAS_IDLE = 1'b1
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic strobe,
	input wire logic cause,
	input wire logic idle
);

	// Strobes last exactly one clock
	a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		strobe |=> !strobe) else $error("strobe held longer than one clock");

	// Every cause gives a strobe on the next clock
	a_follows: assert property (@(posedge clk) disable iff (!rst_n)
		cause |=> strobe) else $error("strobe missing one clock after its cause");

	// And no strobe without one
	a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n)
		strobe |-> $past(cause)) else $error("strobe without a cause");

	// Nothing published while the gate is still waiting
	if (HAS_IDLE) begin : g_idle
		a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
			idle |-> !strobe) else $error("strobe while gate idle");
	end

endmodule

// Counter: done follows a closing sync edge, never in GATE_WAIT
bind photon_gate_counter photon_counter_props u_gate_props (
	.clk    (clk),
	.rst_n  (rst_n),
	.strobe (res.done),
	.cause  (sync_rise && state == photon_pkg::GATE_COUNT),
	.idle   (state == photon_pkg::GATE_WAIT)
);

// Output stage: count_valid one clock behind done
bind count_result_out photon_counter_props #(.HAS_IDLE(1'b0)) u_out_props (
	.clk    (clk),
	.rst_n  (rst_n),
	.strobe (count_valid),
	.cause  (res.done),
	.idle   (1'b0)
);

`default_nettype wire

// ==== rtl/photon_counter_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module photon_counter_top #(
	parameter int unsigned PHOTON_DIV_FAST = 80,
	parameter int unsigned PHOTON_DIV_SLOW = 800,
	parameter int unsigned SYNC_DIV        = 800_000
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   test_en,
	input  wire photon_pkg::test_rate_e rate_sel,
	input  wire logic                   photon_in,
	input  wire logic                   sync_in,
	output photon_pkg::photon_count_t   count,
	output photon_pkg::period_len_t     period,
	output logic                        overflow,
	output logic                        count_valid,
	output logic                        photon_test,
	output logic                        sync_test
);

	logic photon_rise;
	logic sync_rise;

	// Finished period, counter to output stage
	count_if res_if ();

	// Generator outputs also go to pins as scope monitor points
	test_signal_gen #(
		.PHOTON_DIV_FAST (PHOTON_DIV_FAST),
		.PHOTON_DIV_SLOW (PHOTON_DIV_SLOW),
		.SYNC_DIV        (SYNC_DIV)
	) u_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.rate_sel    (rate_sel),
		.photon_test (photon_test),
		.sync_test   (sync_test)
	);

	// Input side
	pulse_sync_detect u_detect (
		.clk         (clk),
		.rst_n       (rst_n),
		.test_en     (test_en),
		.photon_ext  (photon_in),
		.sync_ext    (sync_in),
		.photon_test (photon_test),
		.sync_test   (sync_test),
		.photon_rise (photon_rise),
		.sync_rise   (sync_rise)
	);

	photon_gate_counter u_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.photon_rise (photon_rise),
		.sync_rise   (sync_rise),
		.res         (res_if.src)
	);

	// Output side
	count_result_out u_out (
		.clk         (clk),
		.rst_n       (rst_n),
		.res         (res_if.dst),
		.count       (count),
		.period      (period),
		.overflow    (overflow),
		.count_valid (count_valid)
	);

endmodule

`default_nettype wire

// ==== rtl/count_result_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module count_result_out (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	count_if.dst                        res,
	output photon_pkg::photon_count_t   count,
	output photon_pkg::period_len_t     period,
	output logic                        overflow,
	output logic                        count_valid
);

	// Valid strobe, one clock after done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_valid <= 1'b0;
		end else begin
			count_valid <= res.done;
		end
	end

	// Held result, stable until the next period closes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count    <= '0;
			period   <= '0;
			overflow <= 1'b0;
		end else if (res.done) begin
			count    <= res.photons;
			period   <= res.period_len;
			overflow <= res.overflow;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/photon_gate_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module photon_gate_counter (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic photon_rise,
	input  wire logic sync_rise,
	count_if.src      res
);
	import photon_pkg::*;

	gate_state_e   state;
	photon_count_t photons;
	photon_count_t photons_inc;
	period_len_t   timer;
	period_len_t   timer_inc;

	////////////////////////////////////////////////////////////////////
	// Saturating next values
	////////////////////////////////////////////////////////////////////

	// Count sticks at max
	assign photons_inc = (photon_rise && photons != COUNT_MAX) ?
		photons + 1'b1 : photons;
	// Timer sticks at max
	assign timer_inc = (timer != PERIOD_MAX) ? timer + 1'b1 : timer;

	////////////////////////////////////////////////////////////////////
	// Gate FSM, count and timer
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= GATE_WAIT;
			photons  <= '0;
			timer    <= '0;
			res.done <= 1'b0;
		end else begin
			res.done <= 1'b0;
			case (state)
				GATE_WAIT: begin
					// First sync edge opens a period
					if (sync_rise) begin
						state   <= GATE_COUNT;
						photons <= photon_count_t'(photon_rise);
						timer   <= period_len_t'(1);
					end
				end
				GATE_COUNT: begin
					if (sync_rise) begin
						// Close this period, open the next
						// Photon on the same clock goes to the new period
						res.done <= 1'b1;
						photons  <= photon_count_t'(photon_rise);
						timer    <= period_len_t'(1);
					end else begin
						photons <= photons_inc;
						timer   <= timer_inc;
					end
				end
				default: state <= GATE_WAIT;
			endcase
		end
	end

	// Result payload captured with each sync edge
	// Only looked at while done is high
	always_ff @(posedge clk) begin
		if (sync_rise) begin
			res.photons    <= photons;
			res.overflow   <= (photons == COUNT_MAX);
			res.period_len <= timer;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pulse_sync_detect.sv ====
`timescale 1ns/1ns
`default_nettype none

module pulse_sync_detect (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic test_en,
	input  wire logic photon_ext,
	input  wire logic sync_ext,
	input  wire logic photon_test,
	input  wire logic sync_test,
	output logic      photon_rise,
	output logic      sync_rise
);

	// Bit 0 photon, bit 1 sync
	logic [1:0] src_sel;
	logic [1:0] meta_q;
	logic [1:0] sync_q;
	logic [1:0] hist_q;
	logic [1:0] rise_q;

	// Source select, external pins or built-in generator
	assign src_sel = test_en ? {sync_test, photon_test} : {sync_ext, photon_ext};

	// Two-flop synchronizer then history flop
	// Both lanes share the same stages so latency matches
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			meta_q <= '0;
			sync_q <= '0;
			hist_q <= '0;
			rise_q <= '0;
		end else begin
			meta_q <= src_sel;
			sync_q <= meta_q;
			hist_q <= sync_q;
			// Registered edge pulse, one clock wide
			rise_q <= sync_q & ~hist_q;
		end
	end

	assign photon_rise = rise_q[0];
	assign sync_rise   = rise_q[1];

endmodule

`default_nettype wire

// ==== rtl/test_signal_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module test_signal_gen #(
	parameter int unsigned PHOTON_DIV_FAST = 80,
	parameter int unsigned PHOTON_DIV_SLOW = 800,
	parameter int unsigned SYNC_DIV        = 800_000
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire photon_pkg::test_rate_e rate_sel,
	output logic                        photon_test,
	output logic                        sync_test
);
	import photon_pkg::*;

	// Counter widths sized from the larger divisor
	localparam int unsigned PH_MAX = (PHOTON_DIV_FAST > PHOTON_DIV_SLOW) ?
		PHOTON_DIV_FAST : PHOTON_DIV_SLOW;
	localparam int unsigned PH_W   = $clog2(PH_MAX + 1);
	localparam int unsigned SYNC_W = $clog2(SYNC_DIV + 1);

	// Terminal counts, one less than the half-period
	localparam logic [PH_W-1:0]   FAST_LAST = PH_W'(PHOTON_DIV_FAST - 1);
	localparam logic [PH_W-1:0]   SLOW_LAST = PH_W'(PHOTON_DIV_SLOW - 1);
	localparam logic [SYNC_W-1:0] SYNC_LAST = SYNC_W'(SYNC_DIV - 1);

	logic [PH_W-1:0]   ph_cnt;
	logic [PH_W-1:0]   ph_last;
	logic              ph_on;
	test_rate_e        rate_q;
	logic [SYNC_W-1:0] sync_cnt;

	////////////////////////////////////////////////////////////////////
	// Photon pulse train
	////////////////////////////////////////////////////////////////////

	// Rate opcode picks the terminal count
	always_comb begin
		ph_on   = 1'b1;
		ph_last = FAST_LAST;
		case (rate_sel)
			TEST_FAST: ph_last = FAST_LAST;
			TEST_SLOW: ph_last = SLOW_LAST;
			default:   ph_on   = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rate_q      <= TEST_OFF;
			ph_cnt      <= '0;
			photon_test <= 1'b0;
		end else begin
			rate_q <= rate_sel;
			if (!ph_on) begin
				// Off: output parked low
				ph_cnt      <= '0;
				photon_test <= 1'b0;
			end else if (rate_sel != rate_q) begin
				// New rate restarts the divider
				ph_cnt <= '0;
			end else if (ph_cnt == ph_last) begin
				ph_cnt      <= '0;
				photon_test <= ~photon_test;
			end else begin
				ph_cnt <= ph_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Mains sync square wave
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_cnt  <= '0;
			sync_test <= 1'b0;
		end else if (sync_cnt >= SYNC_LAST) begin
			sync_cnt  <= '0;
			sync_test <= ~sync_test;
		end else begin
			sync_cnt <= sync_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/count_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface count_if;
	import photon_pkg::*;

	// One-cycle end of period marker
	logic          done;
	// Payload, meaningful only with done
	photon_count_t photons;
	logic          overflow;
	period_len_t   period_len;

	// Counter side
	modport src (
		output done,
		output photons,
		output overflow,
		output period_len
	);

	// Output stage side
	modport dst (
		input done,
		input photons,
		input overflow,
		input period_len
	);

endinterface

`default_nettype wire

// ==== rtl/photon_pkg.sv ====
`default_nettype none

package photon_pkg;

	////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////

	// Photons per sync period
	localparam int unsigned COUNT_W  = 16;
	// 1,600,000 clocks per 50 Hz period at 80 MHz fits in 24 bits
	localparam int unsigned PERIOD_W = 24;

	typedef logic [COUNT_W-1:0]  photon_count_t;
	typedef logic [PERIOD_W-1:0] period_len_t;

	// Saturation limits
	localparam photon_count_t COUNT_MAX  = '1;
	localparam period_len_t   PERIOD_MAX = '1;

	////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////

	// Generator photon rate, code 3 acts as off
	typedef enum logic [1:0] {
		TEST_OFF  = 2'd0,
		TEST_FAST = 2'd1,
		TEST_SLOW = 2'd2
	} test_rate_e;

	// Gate FSM
	typedef enum logic {
		GATE_WAIT  = 1'b0,
		GATE_COUNT = 1'b1
	} gate_state_e;

endpackage

`default_nettype wire
